/* logic/nco_defs.svh */
/*
 * Clock generator widths, register addresses and control bit positions
 */
`ifndef NCO_DEFS_SVH
`define NCO_DEFS_SVH

`define NCO_WB_DW         16
`define NCO_WB_AW         2
`define NCO_INT_W         16
`define NCO_FRAC_W        16
`define NCO_PERIOD_W      32

// word addresses on the Wishbone bus
`define NCO_ADDR_CTRL     2'd0
`define NCO_ADDR_PER_INT  2'd1
`define NCO_ADDR_PER_FRAC 2'd2
`define NCO_ADDR_STATUS   2'd3

`define NCO_CTRL_EN_BIT   0
`define NCO_CTRL_SRST_BIT 1

`endif

/* logic/nco_pkg.sv */
/*
 * Shared types for the clock generator
 */
`default_nettype none
`include "nco_defs.svh"

package nco_pkg;

   // integer part in the upper half, fraction below
   typedef struct packed {
      logic [`NCO_INT_W-1:0]  int_part;
      logic [`NCO_FRAC_W-1:0] frac_part;
   } period_fields_t;

   // raw view for compare and subtract, fields for bus and duty logic
   typedef union packed {
      logic [`NCO_PERIOD_W-1:0] raw;
      period_fields_t           fields;
   } period_u;

endpackage

`default_nettype wire

/* logic/nco_csr_wb.sv */
/*
 * Clock generator register file on a Wishbone classic slave.
 * Pairs the two period halves into one commit and reports update status.
 */
`default_nettype none
`include "nco_defs.svh"

module nco_csr_wb (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  logic                      wb_cyc_i,
   input  logic                      wb_stb_i,
   input  logic                      wb_we_i,
   input  logic [`NCO_WB_AW-1:0]     wb_adr_i,
   input  logic [`NCO_WB_DW-1:0]     wb_dat_i,
   input  logic [`NCO_WB_DW/8-1:0]   wb_sel_i,
   input  logic                      update_busy_i,
   output logic [`NCO_WB_DW-1:0]     wb_dat_o,
   output logic                      wb_ack_o,
   output logic                      enable_o,
   output logic                      soft_reset_o,
   output nco_pkg::period_u          period_o,
   output logic                      period_commit_o
);

   import nco_pkg::*;

   logic [1:0]            ctrl_q;
   period_u               period_q;
   // bit 1 integer half seen, bit 0 fractional half seen
   logic [1:0]            written_q;
   logic                  access;
   logic                  wr_ctrl;
   logic                  wr_int;
   logic                  wr_frac;
   logic [`NCO_WB_DW-1:0] rd_data;

   // byte-lane merge of a write into a 16-bit register
   function automatic logic [`NCO_WB_DW-1:0] merge_lanes(
      input logic [`NCO_WB_DW-1:0]   old_val,
      input logic [`NCO_WB_DW-1:0]   new_val,
      input logic [`NCO_WB_DW/8-1:0] sel
   );
      logic [`NCO_WB_DW-1:0] res;
      res = old_val;
      for (int b = 0; b < `NCO_WB_DW/8; b++) begin
         if (sel[b]) begin
            res[b*8 +: 8] = new_val[b*8 +: 8];
         end
      end
      return res;
   endfunction

   assign access  = wb_cyc_i & wb_stb_i & ~wb_ack_o;
   assign wr_ctrl = access & wb_we_i & (wb_adr_i == `NCO_ADDR_CTRL) & wb_sel_i[0];
   assign wr_int  = access & wb_we_i & (wb_adr_i == `NCO_ADDR_PER_INT) & (|wb_sel_i);
   assign wr_frac = access & wb_we_i & (wb_adr_i == `NCO_ADDR_PER_FRAC) & (|wb_sel_i);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wb_ack_o  <= 1'b0;
         ctrl_q    <= '0;
         period_q  <= '0;
         written_q <= '0;
      end else begin
         wb_ack_o <= access;
         if (wr_ctrl) begin
            ctrl_q[`NCO_CTRL_EN_BIT]   <= wb_dat_i[`NCO_CTRL_EN_BIT];
            ctrl_q[`NCO_CTRL_SRST_BIT] <= wb_dat_i[`NCO_CTRL_SRST_BIT];
         end
         if (ctrl_q[`NCO_CTRL_SRST_BIT]) begin
            period_q  <= '0;
            written_q <= '0;
         end else begin
            if (wr_int) begin
               period_q.fields.int_part <=
                  merge_lanes(period_q.fields.int_part, wb_dat_i, wb_sel_i);
            end
            if (wr_frac) begin
               period_q.fields.frac_part <=
                  merge_lanes(period_q.fields.frac_part, wb_dat_i, wb_sel_i);
            end
            // flags clear in the commit cycle
            if (&written_q) begin
               written_q <= {wr_int, wr_frac};
            end else begin
               written_q <= written_q | {wr_int, wr_frac};
            end
         end
      end
   end

   always_comb begin
      rd_data = '0;
      case (wb_adr_i)
         `NCO_ADDR_CTRL:     rd_data[1:0] = ctrl_q;
         `NCO_ADDR_PER_INT:  rd_data = period_q.fields.int_part;
         `NCO_ADDR_PER_FRAC: rd_data = period_q.fields.frac_part;
         `NCO_ADDR_STATUS:   rd_data[0] = update_busy_i;
         default:            rd_data = '0;
      endcase
   end

   // read data is valid alongside ack
   always_ff @(posedge clk_i) begin
      if (access && !wb_we_i) begin
         wb_dat_o <= rd_data;
      end
   end

   assign enable_o        = ctrl_q[`NCO_CTRL_EN_BIT];
   assign soft_reset_o    = ctrl_q[`NCO_CTRL_SRST_BIT];
   assign period_o        = period_q;
   assign period_commit_o = &written_q;

endmodule

`default_nettype wire

/* logic/nco_cdc.sv */
/*
 * Crossing from the bus clock into clk_in_i: reset synchroniser,
 * control level synchronisers and a toggle handshake for the period.
 */
`default_nettype none
`include "nco_defs.svh"

module nco_cdc (
   input  logic             clk_i,
   input  logic             rst_n_i,
   input  logic             clk_in_i,
   input  logic             enable_i,
   input  logic             soft_reset_i,
   input  nco_pkg::period_u period_i,
   input  logic             period_commit_i,
   output logic             update_busy_o,
   output logic             in_rst_n_o,
   output logic             enable_o,
   output logic             soft_reset_o,
   output nco_pkg::period_u period_o,
   output logic             period_load_o
);

   import nco_pkg::*;

   // source side
   period_u    hold_q;
   period_u    xfer_q;
   logic       pend_q;
   logic       req_q;
   logic [1:0] ack_sync_q;
   logic       in_flight;
   logic       launch;

   // destination side
   logic [1:0] rst_sync_q;
   logic [2:0] req_sync_q;
   logic [1:0] lvl_meta_q;
   logic [1:0] lvl_q;
   logic       req_edge;

   assign in_flight     = req_q ^ ack_sync_q[1];
   assign launch        = ~in_flight & (pend_q | period_commit_i);
   assign update_busy_o = pend_q | in_flight;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pend_q     <= 1'b0;
         req_q      <= 1'b0;
         ack_sync_q <= '0;
      end else begin
         ack_sync_q <= {ack_sync_q[0], req_sync_q[2]};
         if (launch) begin
            req_q  <= ~req_q;
            pend_q <= 1'b0;
         end else if (period_commit_i) begin
            // wait for the acknowledge, newest value goes next
            pend_q <= 1'b1;
         end
      end
   end

   // xfer_q stays stable while a request is in flight
   always_ff @(posedge clk_i) begin
      if (period_commit_i) begin
         hold_q <= period_i;
      end
      if (launch) begin
         xfer_q <= period_commit_i ? period_i : hold_q;
      end
   end

   // async assert, release on clk_in_i
   always_ff @(posedge clk_in_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rst_sync_q <= '0;
      end else begin
         rst_sync_q <= {rst_sync_q[0], 1'b1};
      end
   end

   assign in_rst_n_o = rst_sync_q[1];
   assign req_edge   = req_sync_q[1] ^ req_sync_q[2];

   always_ff @(posedge clk_in_i or negedge in_rst_n_o) begin
      if (!in_rst_n_o) begin
         req_sync_q    <= '0;
         lvl_meta_q    <= '0;
         lvl_q         <= '0;
         period_o      <= '0;
         period_load_o <= 1'b0;
      end else begin
         req_sync_q    <= {req_sync_q[1:0], req_q};
         lvl_meta_q    <= {soft_reset_i, enable_i};
         lvl_q         <= lvl_meta_q;
         period_load_o <= req_edge;
         if (req_edge) begin
            period_o <= xfer_q;
         end
      end
   end

   assign enable_o     = lvl_q[0];
   assign soft_reset_o = lvl_q[1];

endmodule

`default_nettype wire

/* logic/nco_core.sv */
/*
 * Phase accumulator and output clock register in the clk_in_i domain
 */
`default_nettype none
`include "nco_defs.svh"

module nco_core (
   input  logic             clk_in_i,
   input  logic             in_rst_n_i,
   input  logic             enable_i,
   input  logic             soft_reset_i,
   input  nco_pkg::period_u period_i,
   input  logic             period_load_i,
   output logic             clk_out_o
);

   import nco_pkg::*;

   // 1.0 in fixed point
   localparam logic [`NCO_PERIOD_W-1:0] step_one =
      {{(`NCO_INT_W-1){1'b0}}, 1'b1, {`NCO_FRAC_W{1'b0}}};

   period_u                  period_q;
   period_u                  acc_q;
   logic [`NCO_PERIOD_W-1:0] acc_nxt;
   logic                     duty;

   always_comb begin
      // high above half the integer period
      duty = acc_q.fields.int_part > (period_q.fields.int_part >> 1);
      if (acc_q.raw >= period_q.raw) begin
         acc_nxt = acc_q.raw - period_q.raw;
      end else begin
         acc_nxt = acc_q.raw + step_one;
      end
   end

   always_ff @(posedge clk_in_i or negedge in_rst_n_i) begin
      if (!in_rst_n_i) begin
         period_q  <= '0;
         acc_q     <= '0;
         clk_out_o <= 1'b0;
      end else if (soft_reset_i) begin
         period_q  <= '0;
         acc_q     <= '0;
         clk_out_o <= 1'b0;
      end else begin
         if (period_load_i) begin
            period_q <= period_i;
         end
         // count and output hold while disabled
         if (enable_i) begin
            acc_q.raw <= acc_nxt;
            clk_out_o <= duty;
         end
      end
   end

endmodule

`default_nettype wire

/* logic/nco_clkgen.sv */
/*
 * Numerically controlled clock generator, Wishbone register file,
 * clock domain crossing and phase accumulator core
 */
`default_nettype none
`include "nco_defs.svh"

module nco_clkgen (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  logic                    clk_in_i,
   input  logic                    wb_cyc_i,
   input  logic                    wb_stb_i,
   input  logic                    wb_we_i,
   input  logic [`NCO_WB_AW-1:0]   wb_adr_i,
   input  logic [`NCO_WB_DW-1:0]   wb_dat_i,
   input  logic [`NCO_WB_DW/8-1:0] wb_sel_i,
   output logic [`NCO_WB_DW-1:0]   wb_dat_o,
   output logic                    wb_ack_o,
   output logic                    clk_out_o
);

   import nco_pkg::*;

   // bus clock domain
   logic    enable;
   logic    soft_reset;
   period_u csr_period;
   logic    period_commit;
   logic    update_busy;

   // clk_in_i domain
   logic    in_rst_n;
   logic    enable_sync;
   logic    soft_reset_sync;
   period_u period_sync;
   logic    period_load;

   nco_csr_wb i_nco_csr_wb (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .wb_cyc_i       (wb_cyc_i),
      .wb_stb_i       (wb_stb_i),
      .wb_we_i        (wb_we_i),
      .wb_adr_i       (wb_adr_i),
      .wb_dat_i       (wb_dat_i),
      .wb_sel_i       (wb_sel_i),
      .update_busy_i  (update_busy),
      .wb_dat_o       (wb_dat_o),
      .wb_ack_o       (wb_ack_o),
      .enable_o       (enable),
      .soft_reset_o   (soft_reset),
      .period_o       (csr_period),
      .period_commit_o(period_commit)
   );

   nco_cdc i_nco_cdc (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .clk_in_i       (clk_in_i),
      .enable_i       (enable),
      .soft_reset_i   (soft_reset),
      .period_i       (csr_period),
      .period_commit_i(period_commit),
      .update_busy_o  (update_busy),
      .in_rst_n_o     (in_rst_n),
      .enable_o       (enable_sync),
      .soft_reset_o   (soft_reset_sync),
      .period_o       (period_sync),
      .period_load_o  (period_load)
   );

   nco_core i_nco_core (
      .clk_in_i     (clk_in_i),
      .in_rst_n_i   (in_rst_n),
      .enable_i     (enable_sync),
      .soft_reset_i (soft_reset_sync),
      .period_i     (period_sync),
      .period_load_i(period_load),
      .clk_out_o    (clk_out_o)
   );

endmodule

`default_nettype wire

/* bench/nco_clkgen_tb.sv */
/*
 * Testbench for the clock generator: Wishbone register access, period
 * programming and measurement of the output clock in clk_in_i cycles
 */
`default_nettype none
`include "nco_defs.svh"

module nco_clkgen_tb;

   localparam int n_rand      = 6;
   localparam int max_per     = 41;
   // bus traffic plus five output periods per update, in clk_i cycles
   localparam int per_update  = 5 * max_per * 10 / 8 + 60;
   localparam int cycle_limit = (n_rand + 10) * per_update + 1000;

   logic        clk_i = 1'b0;
   logic        clk_in_i = 1'b0;
   logic        rst_n_i;
   logic        wb_cyc_i;
   logic        wb_stb_i;
   logic        wb_we_i;
   logic [1:0]  wb_adr_i;
   logic [15:0] wb_dat_i;
   logic [1:0]  wb_sel_i;
   logic [15:0] wb_dat_o;
   logic        wb_ack_o;
   logic        clk_out_o;

   int          cycle_cnt = 0;
   int          errors = 0;
   int          test_start_errors = 0;
   int          tests_ok = 0;
   int          tests_bad = 0;
   logic [31:0] lfsr = 32'h0000_89c0;
   logic        ack_seen = 1'b0;

   always #4 clk_i = ~clk_i;
   always #5 clk_in_i = ~clk_in_i;

   nco_clkgen i_nco_clkgen (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .clk_in_i (clk_in_i),
      .wb_cyc_i (wb_cyc_i),
      .wb_stb_i (wb_stb_i),
      .wb_we_i  (wb_we_i),
      .wb_adr_i (wb_adr_i),
      .wb_dat_i (wb_dat_i),
      .wb_sel_i (wb_sel_i),
      .wb_dat_o (wb_dat_o),
      .wb_ack_o (wb_ack_o),
      .clk_out_o(clk_out_o)
   );

   always @(posedge clk_i) begin
      cycle_cnt++;
      if (cycle_cnt >= cycle_limit) begin
         $display("timeout: run exceeded %0d clk_i cycles", cycle_limit);
         $display("Test failed");
         $finish;
      end
   end

   // ack must drop after a single cycle
   always @(negedge clk_i) begin
      assert (!(wb_ack_o && ack_seen)) else begin
         $display("wb_ack_o stayed high for more than one cycle");
         errors++;
      end
      ack_seen <= wb_ack_o;
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;
      end else begin
         return s >> 1;
      end
   endfunction

   task automatic random_bits(input int n, output int val);
      val = 0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         val = (val << 1) | int'(lfsr[0]);
      end
   endtask

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      assert (got == exp) else begin
         $display("Fail %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic bus_write(input logic [1:0] adr, input logic [15:0] dat,
                            input logic [1:0] sel);
      @(negedge clk_i);
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = 1'b1;
      wb_adr_i = adr;
      wb_dat_i = dat;
      wb_sel_i = sel;
      do @(negedge clk_i); while (!wb_ack_o);
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   // strobe stays up past ack as for back-to-back transfers
   task automatic bus_write_held(input logic [1:0] adr, input logic [15:0] dat);
      @(negedge clk_i);
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = 1'b1;
      wb_adr_i = adr;
      wb_dat_i = dat;
      wb_sel_i = 2'b11;
      repeat (3) @(negedge clk_i);
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic bus_read(input logic [1:0] adr, output logic [15:0] dat);
      @(negedge clk_i);
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = 1'b0;
      wb_adr_i = adr;
      do @(negedge clk_i); while (!wb_ack_o);
      dat = wb_dat_o;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
   endtask

   task automatic wait_idle();
      logic [15:0] st;
      do bus_read(`NCO_ADDR_STATUS, st); while (st[0]);
   endtask

   task automatic set_period(input logic [15:0] int_part, input logic [15:0] frac_part);
      bus_write(`NCO_ADDR_PER_INT, int_part, 2'b11);
      bus_write(`NCO_ADDR_PER_FRAC, frac_part, 2'b11);
      wait_idle();
   endtask

   task automatic sync_to_rise();
      do @(negedge clk_in_i); while (clk_out_o);
      do @(negedge clk_in_i); while (!clk_out_o);
   endtask

   // starts on the first high sample, ends on the next rise
   task automatic measure_period(output int hi, output int lo);
      hi = 0;
      lo = 0;
      while (clk_out_o) begin
         hi++;
         @(negedge clk_in_i);
      end
      while (!clk_out_o) begin
         lo++;
         @(negedge clk_in_i);
      end
   endtask

   task automatic check_int_period(input int p);
      int hi;
      int lo;
      sync_to_rise();
      // first period may still carry the old phase
      measure_period(hi, lo);
      repeat (2) begin
         measure_period(hi, lo);
         compare_value("clk_out_o high cycles", hi, p - p / 2);
         compare_value("clk_out_o period", hi + lo, p + 1);
      end
   endtask

   task automatic check_half_period(input int p_int);
      int hi;
      int lo;
      int len_a;
      sync_to_rise();
      measure_period(hi, lo);
      measure_period(hi, lo);
      len_a = hi + lo;
      measure_period(hi, lo);
      compare_value("clk_out_o period pair", len_a + hi + lo, 2 * p_int + 3);
      assert (len_a == p_int + 1 || len_a == p_int + 2) else begin
         $display("Fail clk_out_o period: got %h, expected %h or %h",
                  len_a, p_int + 1, p_int + 2);
         errors++;
      end
   endtask

   task automatic expect_steady(input int cycles, input logic level);
      repeat (cycles) begin
         @(negedge clk_in_i);
         compare_value("clk_out_o", {31'h0, clk_out_o}, {31'h0, level});
      end
   endtask

   task automatic finish_test(input int num, input string name);
      if (errors == test_start_errors) begin
         tests_ok++;
         $display("test %0d %s: ok", num, name);
      end else begin
         tests_bad++;
         $display("test %0d %s: %0d errors", num, name, errors - test_start_errors);
      end
      test_start_errors = errors;
   endtask

   initial begin
      int          p;
      int          r;
      logic [15:0] rd;
      logic        lv;
      rst_n_i  = 1'b0;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
      wb_adr_i = '0;
      wb_dat_i = '0;
      wb_sel_i = '0;
      p = 2;
      repeat (5) @(posedge clk_i);
      @(negedge clk_i);
      rst_n_i = 1'b1;

      // reset values, read back and byte lanes
      expect_steady(20, 1'b0);
      for (int a = 0; a < 4; a++) begin
         bus_read(a[1:0], rd);
         compare_value("wb_dat_o", {16'h0, rd}, 32'h0);
      end
      bus_write(`NCO_ADDR_PER_INT, 16'h1234, 2'b11);
      bus_read(`NCO_ADDR_PER_INT, rd);
      compare_value("wb_dat_o", {16'h0, rd}, 32'h1234);
      bus_write(`NCO_ADDR_PER_FRAC, 16'habcd, 2'b11);
      bus_read(`NCO_ADDR_PER_FRAC, rd);
      compare_value("wb_dat_o", {16'h0, rd}, 32'habcd);
      bus_write(`NCO_ADDR_PER_INT, 16'h5678, 2'b01);
      bus_read(`NCO_ADDR_PER_INT, rd);
      compare_value("wb_dat_o", {16'h0, rd}, 32'h1278);
      bus_write(`NCO_ADDR_PER_INT, 16'h9abc, 2'b10);
      bus_read(`NCO_ADDR_PER_INT, rd);
      compare_value("wb_dat_o", {16'h0, rd}, 32'h9a78);
      bus_write_held(`NCO_ADDR_PER_INT, 16'h9a78);
      finish_test(1, "reset and register access");

      bus_write(`NCO_ADDR_CTRL, 16'h0001, 2'b01);
      for (int i = 0; i < n_rand; i++) begin
         random_bits(6, r);
         p = 2 + r % 39;
         set_period(p[15:0], 16'h0000);
         check_int_period(p);
      end
      finish_test(2, "random integer periods");

      // a single half must not commit
      bus_write(`NCO_ADDR_PER_INT, 16'd7, 2'b11);
      repeat (30) @(negedge clk_in_i);
      check_int_period(p);
      bus_write(`NCO_ADDR_PER_FRAC, 16'h0000, 2'b11);
      wait_idle();
      check_int_period(7);
      bus_write(`NCO_ADDR_PER_FRAC, 16'h8000, 2'b11);
      repeat (30) @(negedge clk_in_i);
      check_int_period(7);
      bus_write(`NCO_ADDR_PER_INT, 16'd12, 2'b11);
      wait_idle();
      check_half_period(12);
      finish_test(3, "paired period halves");

      set_period(16'd9, 16'h8000);
      check_half_period(9);
      finish_test(4, "fractional period");

      bus_write(`NCO_ADDR_CTRL, 16'h0000, 2'b01);
      repeat (10) @(negedge clk_in_i);
      lv = clk_out_o;
      expect_steady(40, lv);
      bus_write(`NCO_ADDR_CTRL, 16'h0001, 2'b01);
      check_half_period(9);
      finish_test(5, "enable freeze and resume");

      bus_write(`NCO_ADDR_CTRL, 16'h0003, 2'b01);
      repeat (10) @(negedge clk_in_i);
      expect_steady(20, 1'b0);
      bus_read(`NCO_ADDR_PER_INT, rd);
      compare_value("wb_dat_o", {16'h0, rd}, 32'h0);
      bus_read(`NCO_ADDR_PER_FRAC, rd);
      compare_value("wb_dat_o", {16'h0, rd}, 32'h0);
      bus_write(`NCO_ADDR_CTRL, 16'h0001, 2'b01);
      expect_steady(60, 1'b0);
      set_period(16'd5, 16'h0000);
      check_int_period(5);
      finish_test(6, "soft reset");

      $display("passed tests: %0d, failing tests: %0d, check errors: %0d",
               tests_ok, tests_bad, errors);
      if (errors == 0 && tests_bad == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* nco_clkgen.f */
+incdir+logic
logic/nco_pkg.sv
logic/nco_csr_wb.sv
logic/nco_cdc.sv
logic/nco_core.sv
logic/nco_clkgen.sv
bench/nco_clkgen_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the clock generator testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --top-module nco_clkgen_tb -f nco_clkgen.f --Mdir obj_dir -o nco_clkgen_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/nco_clkgen_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Test failed" sim.log; then
   exit 1
fi
exit 0
